//--- Bender.yml
package:
  name: idct

sources:
  - include_dirs:
      - logic
    files:
      - logic/idct_pkg.sv
      - logic/idct_mul.sv
      - logic/idct_butterfly.sv
      - logic/idct_wb_slave.sv
      - logic/idct_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/idct_checker.sv
      - tb/idct_asserts.sv
      - tb/tb_idct.sv

//--- flist.f
+incdir+logic
logic/idct_pkg.sv
logic/idct_mul.sv
logic/idct_butterfly.sv
logic/idct_wb_slave.sv
logic/idct_top.sv
tb/idct_checker.sv
tb/idct_asserts.sv
tb/tb_idct.sv

//--- logic/idct_butterfly.sv
`include "idct_consts.svh"

module idct_butterfly (
    input  logic                   clk,
    input  logic                   rst,
    input  idct_pkg::idct_prod_s   prod,
    output idct_pkg::idct_res_s    res
);
    import idct_pkg::*;

    // Shared (xa+xb)*C terms of the odd rotations
    acc_t s17_c7, s17_c5, s35_c5, s35_c7;
    acc_t rot_p, rot_q, rot_r, rot_s; // C1/C7 on x1,x7 and C3/C5 on x3,x5
    acc_t rot_t, rot_u, rot_v, rot_w; // C3/C5 on x1,x7 and C1/C7 on x3,x5

    acc_t a0_q, a1_q, b0_q, b1_q; // Stage one, even part
    acc_t o0_q, o1_q, o2_q, o3_q; // Stage one, odd part
    logic vld1_q;

    acc_t e0, e1, e2, e3;

    // Round, drop the fraction and keep 16 bits
    function automatic sample_t rnd_shift(acc_t v);
        acc_t t;
        t = (v + `IDCT_ROUND) >>> `IDCT_FRAC_BITS;
        return t[15:0];
    endfunction

    ////////////////////////////////////////
    // Stage one
    ////////////////////////////////////////
    always_comb begin
        s17_c7 = $signed(prod.in1_c7) + $signed(prod.in7_c7);
        s17_c5 = $signed(prod.in1_c5) + $signed(prod.in7_c5);
        s35_c5 = $signed(prod.in3_c5) + $signed(prod.in5_c5);
        s35_c7 = $signed(prod.in3_c7) + $signed(prod.in5_c7);

        rot_p = s17_c7 + $signed(prod.in1_c9);  // x1*C1 + x7*C7
        rot_q = s17_c7 - $signed(prod.in7_c8);  // x1*C7 - x7*C1
        rot_r = s35_c5 + $signed(prod.in3_c11); // x3*C3 + x5*C5
        rot_s = $signed(prod.in5_c10) - s35_c5; // x5*C3 - x3*C5
        rot_t = $signed(prod.in1_c10) - s17_c5; // x1*C3 - x7*C5
        rot_u = s17_c5 + $signed(prod.in7_c11); // x1*C5 + x7*C3
        rot_v = s35_c7 + $signed(prod.in5_c9);  // x3*C7 + x5*C1
        rot_w = $signed(prod.in3_c8) - s35_c7;  // x3*C1 - x5*C7
    end

    always_ff @(posedge clk) begin
        a0_q <= $signed(prod.in0_c4) + $signed(prod.in4_c4);
        a1_q <= $signed(prod.in0_c4) - $signed(prod.in4_c4);
        b0_q <= $signed(prod.in2_c2) + $signed(prod.in6_c6);
        b1_q <= $signed(prod.in2_c6) - $signed(prod.in6_c2);
        o0_q <= rot_p + rot_r;
        o1_q <= rot_t - rot_v;
        o2_q <= rot_u - rot_w;
        o3_q <= rot_q + rot_s;
        if (rst) begin
            vld1_q <= 1'b0;
        end else begin
            vld1_q <= prod.valid;
        end
    end

    ////////////////////////////////////////
    // Stage two
    ////////////////////////////////////////
    always_comb begin
        e0 = a0_q + b0_q;
        e1 = a1_q + b1_q;
        e2 = a1_q - b1_q;
        e3 = a0_q - b0_q;
    end

    always_ff @(posedge clk) begin
        res.y0 <= rnd_shift(e0 + o0_q);
        res.y1 <= rnd_shift(e1 + o1_q);
        res.y2 <= rnd_shift(e2 + o2_q);
        res.y3 <= rnd_shift(e3 + o3_q);
        res.y4 <= rnd_shift(e3 - o3_q); // Mirror half
        res.y5 <= rnd_shift(e2 - o2_q);
        res.y6 <= rnd_shift(e1 - o1_q);
        res.y7 <= rnd_shift(e0 - o0_q);
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= vld1_q;
        end
    end

endmodule

//--- logic/idct_consts.svh
`ifndef IDCT_CONSTS_SVH
`define IDCT_CONSTS_SVH

////////////////////////////////////////
// Cosine constants, cos(k*pi/16) x4096
////////////////////////////////////////
`define IDCT_C1 4017 // cos( pi/16)
`define IDCT_C2 3784 // cos(2pi/16)
`define IDCT_C3 3406 // cos(3pi/16)
`define IDCT_C4 2896 // cos(4pi/16)
`define IDCT_C5 2276 // cos(5pi/16)
`define IDCT_C6 1567 // cos(6pi/16)
`define IDCT_C7 799  // cos(7pi/16)

// Combined constants for the rotations
`define IDCT_C8  (`IDCT_C1 + `IDCT_C7)
`define IDCT_C9  (`IDCT_C1 - `IDCT_C7)
`define IDCT_C10 (`IDCT_C3 + `IDCT_C5)
`define IDCT_C11 (`IDCT_C3 - `IDCT_C5)

// Fixed point
`define IDCT_FRAC_BITS 12
`define IDCT_ROUND     2048 // Half LSB of the result

////////////////////////////////////////
// Register map, word address = adr[4:2]
////////////////////////////////////////
`define IDCT_ADR_DIN0   3'd0
`define IDCT_ADR_DIN1   3'd1 // Write launches
`define IDCT_ADR_STATUS 3'd2
`define IDCT_ADR_DOUT0  3'd4
`define IDCT_ADR_DOUT1  3'd5
`define IDCT_ADR_DOUT2  3'd6
`define IDCT_ADR_DOUT3  3'd7

`endif

//--- logic/idct_mul.sv
`include "idct_consts.svh"

module idct_mul (
    input  logic                   clk,
    input  logic                   rst,
    input  idct_pkg::idct_blk_s    blk,
    output idct_pkg::idct_prod_s   prod
);
    import idct_pkg::*;

    idct_prod_s prod_d; // Products before the register

    // Zero-extend the sample, constant fits in 13 bits
    function automatic prod_t cmul(pixel_t x, prod_t c);
        return prod_t'(x) * c;
    endfunction

    ////////////////////////////////////////
    // Constant products
    ////////////////////////////////////////
    always_comb begin
        prod_d.valid   = blk.valid;
        prod_d.in0_c4  = cmul(blk.x0, `IDCT_C4);
        prod_d.in4_c4  = cmul(blk.x4, `IDCT_C4);
        prod_d.in2_c2  = cmul(blk.x2, `IDCT_C2);
        prod_d.in2_c6  = cmul(blk.x2, `IDCT_C6);
        prod_d.in6_c2  = cmul(blk.x6, `IDCT_C2);
        prod_d.in6_c6  = cmul(blk.x6, `IDCT_C6);
        // x1 and x7 share the (x1+x7) terms in the butterfly
        prod_d.in1_c7  = cmul(blk.x1, `IDCT_C7);
        prod_d.in7_c7  = cmul(blk.x7, `IDCT_C7);
        prod_d.in1_c9  = cmul(blk.x1, `IDCT_C9);
        prod_d.in7_c8  = cmul(blk.x7, `IDCT_C8);
        prod_d.in1_c5  = cmul(blk.x1, `IDCT_C5);
        prod_d.in7_c5  = cmul(blk.x7, `IDCT_C5);
        prod_d.in1_c10 = cmul(blk.x1, `IDCT_C10);
        prod_d.in7_c11 = cmul(blk.x7, `IDCT_C11);
        // Same idea for x3 and x5
        prod_d.in3_c7  = cmul(blk.x3, `IDCT_C7);
        prod_d.in5_c7  = cmul(blk.x5, `IDCT_C7);
        prod_d.in5_c9  = cmul(blk.x5, `IDCT_C9);
        prod_d.in3_c8  = cmul(blk.x3, `IDCT_C8);
        prod_d.in3_c5  = cmul(blk.x3, `IDCT_C5);
        prod_d.in5_c5  = cmul(blk.x5, `IDCT_C5);
        prod_d.in5_c10 = cmul(blk.x5, `IDCT_C10);
        prod_d.in3_c11 = cmul(blk.x3, `IDCT_C11);
    end

    always_ff @(posedge clk) begin
        prod <= prod_d;
        if (rst) begin
            prod.valid <= 1'b0; // Only the valid bit is control
        end
    end

endmodule

//--- logic/idct_pkg.sv
package idct_pkg;

    ////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////
    typedef logic [7:0]          pixel_t;  // Unsigned input sample
    typedef logic [31:0]         prod_t;   // Sample times constant
    typedef logic signed [31:0]  acc_t;    // Butterfly sum
    typedef logic signed [15:0]  sample_t; // Output value

    // One input block, x0 in the low bits
    typedef struct packed {
        logic   valid;
        pixel_t x7;
        pixel_t x6;
        pixel_t x5;
        pixel_t x4;
        pixel_t x3;
        pixel_t x2;
        pixel_t x1;
        pixel_t x0;
    } idct_blk_s;

    // Constant products of one block
    typedef struct packed {
        logic  valid;
        prod_t in0_c4;  // Even part
        prod_t in4_c4;
        prod_t in2_c2;
        prod_t in2_c6;
        prod_t in6_c2;
        prod_t in6_c6;
        prod_t in1_c7;  // x1/x7 rotation by C1/C7
        prod_t in7_c7;
        prod_t in1_c9;
        prod_t in7_c8;
        prod_t in1_c5;  // x1/x7 rotation by C3/C5
        prod_t in7_c5;
        prod_t in1_c10;
        prod_t in7_c11;
        prod_t in3_c7;  // x3/x5 rotation by C1/C7
        prod_t in5_c7;
        prod_t in5_c9;
        prod_t in3_c8;
        prod_t in3_c5;  // x3/x5 rotation by C3/C5
        prod_t in5_c5;
        prod_t in5_c10;
        prod_t in3_c11;
    } idct_prod_s;

    typedef struct packed {
        logic    valid;
        sample_t y7;
        sample_t y6;
        sample_t y5;
        sample_t y4;
        sample_t y3;
        sample_t y2;
        sample_t y1;
        sample_t y0;
    } idct_res_s;

    ////////////////////////////////////////
    // Wishbone classic
    ////////////////////////////////////////
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } wb_req_s;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat; // Valid with ack
    } wb_rsp_s;

endpackage

//--- logic/idct_top.sv
module idct_top (
    input  logic                clk,
    input  logic                rst,
    input  idct_pkg::wb_req_s   wb_req,
    output idct_pkg::wb_rsp_s   wb_rsp
);
    import idct_pkg::*;

    idct_blk_s  blk;  // Slave to multiplier, valid at launch
    idct_prod_s prod; // One cycle later
    idct_res_s  res;  // Three cycles after launch

    ////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////
    idct_wb_slave u_slave (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .blk    (blk),
        .res    (res)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////
    idct_mul u_mul (
        .clk  (clk),
        .rst  (rst),
        .blk  (blk),
        .prod (prod)
    );

    idct_butterfly u_bfly (
        .clk  (clk),
        .rst  (rst),
        .prod (prod),
        .res  (res)
    );

endmodule

//--- logic/idct_wb_slave.sv
`include "idct_consts.svh"

module idct_wb_slave (
    input  logic                   clk,
    input  logic                   rst,
    input  idct_pkg::wb_req_s      wb_req,
    output idct_pkg::wb_rsp_s      wb_rsp,
    output idct_pkg::idct_blk_s    blk,
    input  idct_pkg::idct_res_s    res
);
    import idct_pkg::*;

    logic        req;       // New request, not yet acked
    logic        adr_hit;   // Upper address bits clear
    logic [2:0]  wadr;      // Word address
    logic        launch;    // DIN1 write sampled
    logic        launch_q;
    logic [31:0] din0;
    logic [31:0] din1;
    logic [31:0] dout [4];
    logic [1:0]  in_flight; // 0 to 3 blocks in the pipe
    logic        done;
    logic        busy;
    logic [31:0] rdat;

    // Byte lane merge for writes
    function automatic logic [31:0] be_merge(logic [31:0] cur, logic [31:0] wdat,
                                             logic [3:0] sel);
        logic [31:0] r;
        r = cur;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) r[8*i +: 8] = wdat[8*i +: 8];
        end
        return r;
    endfunction

    assign req     = wb_req.cyc & wb_req.stb & ~wb_rsp.ack; // No second ack
    assign adr_hit = (wb_req.adr[31:5] == '0);
    assign wadr    = wb_req.adr[4:2];
    assign launch  = req & wb_req.we & adr_hit & (wadr == `IDCT_ADR_DIN1);
    assign busy    = (in_flight != 2'd0);

    ////////////////////////////////////////
    // Input registers and launch
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            din0 <= '0;
            din1 <= '0;
        end else if (req & wb_req.we & adr_hit) begin
            case (wadr)
                `IDCT_ADR_DIN0: din0 <= be_merge(din0, wb_req.dat, wb_req.sel);
                `IDCT_ADR_DIN1: din1 <= be_merge(din1, wb_req.dat, wb_req.sel);
                default: ; // Read-only or unmapped
            endcase
        end
    end

    // Block valid lines up with the ack of the DIN1 write
    assign blk.valid = launch_q;
    assign blk.x0    = din0[7:0];
    assign blk.x1    = din0[15:8];
    assign blk.x2    = din0[23:16];
    assign blk.x3    = din0[31:24];
    assign blk.x4    = din1[7:0];
    assign blk.x5    = din1[15:8];
    assign blk.x6    = din1[23:16];
    assign blk.x7    = din1[31:24];

    ////////////////////////////////////////
    // Status and results
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            launch_q  <= 1'b0;
            in_flight <= 2'd0;
            done      <= 1'b0;
        end else begin
            launch_q <= launch;
            case ({launch, res.valid})
                2'b10:   in_flight <= in_flight + 2'd1;
                2'b01:   in_flight <= in_flight - 2'd1;
                default: ; // Both or neither
            endcase
            // New launch wins over a capture in the same cycle
            if (launch) done <= 1'b0;
            else if (res.valid) done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 4; k++) dout[k] <= '0;
        end else if (res.valid) begin
            dout[0] <= {res.y1, res.y0};
            dout[1] <= {res.y3, res.y2};
            dout[2] <= {res.y5, res.y4};
            dout[3] <= {res.y7, res.y6};
        end
    end

    // Read mux
    always_comb begin
        rdat = '0;
        if (adr_hit) begin
            case (wadr)
                `IDCT_ADR_DIN0:   rdat = din0;
                `IDCT_ADR_DIN1:   rdat = din1;
                `IDCT_ADR_STATUS: rdat = {30'd0, busy, done};
                `IDCT_ADR_DOUT0:  rdat = dout[0];
                `IDCT_ADR_DOUT1:  rdat = dout[1];
                `IDCT_ADR_DOUT2:  rdat = dout[2];
                `IDCT_ADR_DOUT3:  rdat = dout[3];
                default:          rdat = '0;
            endcase
        end
    end

    // One-cycle classic ack, data registered with it
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_rsp.ack <= 1'b0;
            wb_rsp.dat <= '0;
        end else begin
            wb_rsp.ack <= req;
            if (req) wb_rsp.dat <= wb_req.we ? 32'd0 : rdat;
        end
    end

endmodule

//--- tb/idct_asserts.sv
module idct_asserts (
    input logic              clk,
    input logic              rst,
    input idct_pkg::wb_req_s wb_req,
    input idct_pkg::wb_rsp_s wb_rsp,
    input logic              launch,   // Block valid into the multiplier
    input logic              res_valid // Butterfly output valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0; // Failed assertions so far

    ////////////////////////////////////////
    // Wishbone classic
    ////////////////////////////////////////
    ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fails++;
            $error("ack held high for two cycles in a row");
        end

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            fails++;
            $error("ack without cyc and stb");
        end

    ////////////////////////////////////////
    // Pipeline latency
    ////////////////////////////////////////
    res_after_launch: assert property (@(posedge clk) disable iff (rst)
        launch |-> ##3 res_valid)
        else begin
            fails++;
            $error("no butterfly result 3 cycles after launch");
        end

    res_from_launch: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> $past(launch, 3))
        else begin
            fails++;
            $error("butterfly result without a launch 3 cycles earlier");
        end

endmodule

bind idct_top idct_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .launch    (blk.valid),
    .res_valid (res.valid)
);

//--- tb/idct_checker.sv
`include "idct_consts.svh"

module idct_checker (
    input logic              clk,
    input logic              rst,
    input idct_pkg::wb_req_s wb_req,
    input idct_pkg::wb_rsp_s wb_rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import idct_pkg::*;

    string        test_name = "none"; // Set by the testbench per phase
    int           errors = 0;
    int           checks = 0;

    logic [31:0]  din0;
    logic [31:0]  din1;
    logic [31:0]  dout [4];
    logic         done;
    logic         exp_ack;  // Ack expected in the current cycle
    logic         rd_pend;  // Read awaiting its ack
    logic [31:0]  rd_exp;
    logic [31:0]  rd_adr;
    longint       edge_cnt;
    longint       due_q [$]; // Capture edge of each block in flight
    logic [127:0] res_q [$]; // Expected DOUT words of each block

    ////////////////////////////////////////
    // Reference IDCT, straight from the rule
    ////////////////////////////////////////
    function automatic logic [127:0] ref_idct(logic [31:0] d0, logic [31:0] d1);
        int          x [8];
        int          a0, a1, b0, b1;
        int          e [4];
        int          o [4];
        logic [15:0] y [8];
        for (int i = 0; i < 4; i++) begin
            x[i]     = d0[8*i +: 8]; // Unsigned samples
            x[i + 4] = d1[8*i +: 8];
        end
        a0 = (x[0] + x[4]) * `IDCT_C4;
        a1 = (x[0] - x[4]) * `IDCT_C4;
        b0 = x[2] * `IDCT_C2 + x[6] * `IDCT_C6;
        b1 = x[2] * `IDCT_C6 - x[6] * `IDCT_C2;
        e[0] = a0 + b0;
        e[1] = a1 + b1;
        e[2] = a1 - b1;
        e[3] = a0 - b0;
        o[0] = x[1] * `IDCT_C1 + x[3] * `IDCT_C3 + x[5] * `IDCT_C5 + x[7] * `IDCT_C7;
        o[1] = x[1] * `IDCT_C3 - x[3] * `IDCT_C7 - x[5] * `IDCT_C1 - x[7] * `IDCT_C5;
        o[2] = x[1] * `IDCT_C5 - x[3] * `IDCT_C1 + x[5] * `IDCT_C7 + x[7] * `IDCT_C3;
        o[3] = x[1] * `IDCT_C7 - x[3] * `IDCT_C5 + x[5] * `IDCT_C3 - x[7] * `IDCT_C1;
        for (int k = 0; k < 4; k++) begin
            y[k]     = 16'((e[k] + o[k] + `IDCT_ROUND) >>> `IDCT_FRAC_BITS);
            y[7 - k] = 16'((e[k] - o[k] + `IDCT_ROUND) >>> `IDCT_FRAC_BITS); // Mirror
        end
        return {y[7], y[6], y[5], y[4], y[3], y[2], y[1], y[0]};
    endfunction

    // Register map as seen before the current edge
    function automatic logic [31:0] read_model(logic [31:0] adr);
        if (adr[31:5] != '0) return 32'd0;
        case (adr[4:2])
            `IDCT_ADR_DIN0:   return din0;
            `IDCT_ADR_DIN1:   return din1;
            `IDCT_ADR_STATUS: return {30'd0, due_q.size() != 0, done};
            `IDCT_ADR_DOUT0:  return dout[0];
            `IDCT_ADR_DOUT1:  return dout[1];
            `IDCT_ADR_DOUT2:  return dout[2];
            `IDCT_ADR_DOUT3:  return dout[3];
            default:          return 32'd0;
        endcase
    endfunction

    task automatic report_mismatch(string what, logic [31:0] expv, logic [31:0] actv);
        errors++;
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expv, actv);
    endtask

    ////////////////////////////////////////
    // Cycle model of the bus and the pipe
    ////////////////////////////////////////
    always @(posedge clk) begin
        logic         sampled;
        logic [127:0] r;
        if (rst) begin
            din0     = '0;
            din1     = '0;
            done     = 1'b0;
            exp_ack  = 1'b0;
            rd_pend  = 1'b0;
            edge_cnt = 0;
            due_q.delete();
            res_q.delete();
            for (int k = 0; k < 4; k++) dout[k] = '0;
        end else begin
            edge_cnt++;
            if (wb_rsp.ack !== exp_ack) report_mismatch("ack", {31'd0, exp_ack}, {31'd0, wb_rsp.ack});
            if (exp_ack && rd_pend) begin // Read data arrives with ack
                checks++;
                if (wb_rsp.dat !== rd_exp)
                    report_mismatch($sformatf("read of %h", rd_adr), rd_exp, wb_rsp.dat);
            end
            sampled = wb_req.cyc && wb_req.stb && !exp_ack;
            rd_pend = sampled && !wb_req.we;
            if (rd_pend) begin
                rd_exp = read_model(wb_req.adr);
                rd_adr = wb_req.adr;
            end
            // Result lands four edges after the DIN1 write is sampled
            if (due_q.size() != 0 && due_q[0] == edge_cnt) begin
                r = res_q.pop_front();
                void'(due_q.pop_front());
                for (int k = 0; k < 4; k++) dout[k] = r[32*k +: 32];
                done = 1'b1; // Every capture sets done
            end
            if (sampled && wb_req.we && wb_req.adr[31:5] == '0) begin
                case (wb_req.adr[4:2])
                    `IDCT_ADR_DIN0: din0 = wb_req.dat;
                    `IDCT_ADR_DIN1: begin
                        din1 = wb_req.dat;
                        due_q.push_back(edge_cnt + 4);
                        res_q.push_back(ref_idct(din0, din1));
                        done = 1'b0; // Launch wins over capture
                    end
                    default: ;
                endcase
            end
            exp_ack = sampled;
        end
    end

endmodule

//--- tb/tb_idct.sv
`include "idct_consts.svh"

module tb_idct;
    timeunit 1ns;
    timeprecision 1ps;
    import idct_pkg::*;

    localparam int BUS_TIMEOUT = 20; // Cycles to wait for ack
    localparam int POLL_LIMIT  = 16; // STATUS reads before giving up
    localparam int N_RANDOM    = 500;

    logic        clk;
    logic        rst;
    wb_req_s     wb_req;
    wb_rsp_s     wb_rsp;
    int          timeouts = 0;
    int          blocks = 0;

    idct_top UUT (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    idct_checker u_checker (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    function automatic logic [31:0] reg_adr(logic [2:0] word);
        return {27'd0, word, 2'b00};
    endfunction

    ////////////////////////////////////////
    // Bus tasks, called on a falling edge
    ////////////////////////////////////////
    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        rdat = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.sel = 4'hf;
        wb_req.dat = we ? wdat : 32'd0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < BUS_TIMEOUT);
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat; // Stable mid-cycle
        end else begin
            timeouts++;
            $display("Timeout: no ack within %0d cycles for address %h", BUS_TIMEOUT, adr);
        end
        @(negedge clk); // Hold through the edge that takes ack
        wb_req = '0;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'd0, rdat);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        st = '0;
        polls = 0;
        while (!st[0] && polls < POLL_LIMIT) begin
            bus_read(reg_adr(`IDCT_ADR_STATUS), st);
            polls++;
        end
        if (!st[0]) begin
            timeouts++;
            $display("Timeout: done still clear after %0d STATUS polls", polls);
        end
    endtask

    // Checker compares every read word
    task automatic read_results();
        logic [31:0] rd;
        bus_read(reg_adr(`IDCT_ADR_STATUS), rd); // Busy back to 0
        bus_read(reg_adr(`IDCT_ADR_DOUT0), rd);
        bus_read(reg_adr(`IDCT_ADR_DOUT1), rd);
        bus_read(reg_adr(`IDCT_ADR_DOUT2), rd);
        bus_read(reg_adr(`IDCT_ADR_DOUT3), rd);
    endtask

    task automatic run_block(input logic [31:0] d0, input logic [31:0] d1);
        logic [31:0] st;
        bus_write(reg_adr(`IDCT_ADR_DIN0), d0);
        bus_write(reg_adr(`IDCT_ADR_DIN1), d1);
        bus_read(reg_adr(`IDCT_ADR_STATUS), st); // Done clear, busy set
        wait_done();
        read_results();
        blocks++;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        void'($urandom(32'h17af_d1ae));
        rst = 1'b1;
        wb_req = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        u_checker.test_name = "reset";
        read_results();
        bus_read(reg_adr(`IDCT_ADR_DIN0), rd);

        u_checker.test_name = "edge";
        run_block(32'h0000_0000, 32'h0000_0000);
        run_block(32'hffff_ffff, 32'hffff_ffff);
        run_block(32'h0000_00ff, 32'h0000_0000); // Only x0 set
        run_block(32'hff00_ff00, 32'hff00_ff00); // 0,255 alternating

        u_checker.test_name = "random";
        for (int n = 0; n < N_RANDOM; n++) run_block($urandom(), $urandom());

        u_checker.test_name = "back_to_back";
        for (int n = 0; n < 8; n++) begin
            bus_write(reg_adr(`IDCT_ADR_DIN0), $urandom());
            bus_write(reg_adr(`IDCT_ADR_DIN1), $urandom());
            bus_write(reg_adr(`IDCT_ADR_DIN1), $urandom()); // Last one must stick
            if (n[0]) bus_write(reg_adr(`IDCT_ADR_DIN1), $urandom());
            wait_done();
            read_results();
        end

        u_checker.test_name = "unmapped";
        bus_read(32'h0000_000c, rd);
        bus_read(32'h0000_0020, rd);
        bus_read(32'h8000_0010, rd);
        bus_write(32'h0000_000c, $urandom());
        bus_write(32'h0000_0024, $urandom()); // DIN1 alias above the map
        bus_write(reg_adr(`IDCT_ADR_DOUT0), $urandom());
        bus_write(reg_adr(`IDCT_ADR_STATUS), $urandom());
        read_results();

        $display("Closing: %0d blocks, %0d reads, %0d errors, %0d assert fails, %0d timeouts",
                 blocks, u_checker.checks, u_checker.errors, UUT.u_asserts.fails, timeouts);
        if (u_checker.errors == 0 && UUT.u_asserts.fails == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
